/* src/sd_host_pkg.sv */
// SD host controller shared definitions
// Register map, field positions, frame lengths and status bit positions
// for the AXI4-Lite register block and the CMD line engine
package sd_host_pkg;

  // ******************************
  // Register bus
  // ******************************
  localparam int AXI_ADDR_W = 5;             // Byte address width
  localparam int AXI_DATA_W = 32;

  localparam logic [AXI_ADDR_W-1:0] REG_CMD    = 5'h00; // Index and response flag, write issues
  localparam logic [AXI_ADDR_W-1:0] REG_ARG    = 5'h04; // 32-bit command argument
  localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 5'h08;
  localparam logic [AXI_ADDR_W-1:0] REG_RESP   = 5'h0C; // Card status from a short response
  localparam logic [AXI_ADDR_W-1:0] REG_CLKDIV = 5'h10;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // CMD register fields
  localparam int CMD_INDEX_LSB = 0;          // Index in bits 5..0
  localparam int CMD_RESP_BIT  = 8;          // Set when a short response is expected

  // STATUS register bits
  localparam int ST_BUSY      = 0;
  localparam int ST_DONE      = 1;
  localparam int ST_CRC_ERR   = 2;
  localparam int ST_TIMEOUT   = 3;
  localparam int ST_INDEX_ERR = 4;

  // ******************************
  // SD clock and CMD framing
  // ******************************
  localparam int CLKDIV_W = 8;
  localparam logic [CLKDIV_W-1:0] CLKDIV_RESET = 8'd4; // Period is 2 * (div + 1) system clocks

  localparam int CMD_FRAME_LEN = 48;         // Command and short response alike
  localparam int CMD_HDR_LEN   = 40;         // Bits covered by the CRC7
  localparam int NCR_MAX       = 64;         // SD clock periods allowed before a response start

endpackage

/* src/sd_cmd_if.sv */
// SD command request channel
// Carries one command from the register block to the CMD engine and brings
// the result back: a start pulse one way, busy, done and the flags the other
interface sd_cmd_if;

  logic        start;        // One-cycle request, only while busy is low
  logic [5:0]  index;
  logic [31:0] arg;
  logic        resp_exp;     // Wait for and check a 48-bit response

  logic        busy;         // Rises after start, falls with done
  logic        done;         // One-cycle end of command
  logic [31:0] resp_status;  // Response bits 39..8
  logic        crc_err;      // Flags are valid while done is high
  logic        timeout;
  logic        index_err;

  modport requester (
    output start, index, arg, resp_exp,
    input  busy, done, resp_status, crc_err, timeout, index_err
  );

  modport engine (
    input  start, index, arg, resp_exp,
    output busy, done, resp_status, crc_err, timeout, index_err
  );

endinterface

/* src/sd_crc7.sv */
// Serial CRC7 for SD command and response frames
// Polynomial x^7 + x^3 + 1, one bit per enabled clock, MSB of the frame first
module sd_crc7 (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_clear,   // Zero the register before a new frame
  input  logic       i_en,      // Advance by i_bit
  input  logic       i_bit,
  output logic [6:0] o_crc
);

  logic fb;

  assign fb = i_bit ^ o_crc[6];  // Feedback into taps 0 and 3

  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      o_crc <= 7'd0;
    end else if (i_en) begin
      o_crc <= {o_crc[5:3], o_crc[2] ^ fb, o_crc[1:0], fb};
    end
  end

endmodule

/* src/sd_host_platform.sv */
// SD host platform layer
// Divides the system clock into the SD card clock, marks its edges for the
// engine, registers the CMD drive and synchronizes the CMD input
module sd_host_platform (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [sd_host_pkg::CLKDIV_W-1:0] i_clk_div,
  input  logic                          i_cmd_out,    // Bit the engine wants on the line
  input  logic                          i_cmd_oe,
  input  logic                          i_cmd_pin,    // Raw CMD pad input
  output logic                          o_sd_clk,
  output logic                          o_tx_stb,     // Cycle in which sd_clk fell
  output logic                          o_rx_stb,     // Cycle in which sd_clk rose
  output logic                          o_cmd_pin,
  output logic                          o_cmd_pin_oe,
  output logic                          o_cmd_in      // Synchronized CMD input
);
  import sd_host_pkg::*;

  logic [CLKDIV_W-1:0] div_cnt;
  logic                toggle;
  logic                sync_q1;

  // Compare with >= so that a smaller new divisor takes effect at once
  assign toggle = (div_cnt >= i_clk_div);

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt      <= '0;
      o_sd_clk     <= 1'b0;
      o_tx_stb     <= 1'b0;
      o_rx_stb     <= 1'b0;
      o_cmd_pin    <= 1'b1;
      o_cmd_pin_oe <= 1'b0;
      sync_q1      <= 1'b1;               // Idle CMD line is pulled high
      o_cmd_in     <= 1'b1;
    end else begin
      o_tx_stb <= toggle && o_sd_clk;     // Strobes line up with the new sd_clk level
      o_rx_stb <= toggle && !o_sd_clk;
      if (toggle) begin
        div_cnt  <= '0;
        o_sd_clk <= ~o_sd_clk;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      // Drive changes just after a falling edge, giving the card a half period of setup
      if (o_tx_stb) begin
        o_cmd_pin    <= i_cmd_out;
        o_cmd_pin_oe <= i_cmd_oe;
      end
      sync_q1  <= i_cmd_pin;              // Two flops into the system clock
      o_cmd_in <= sync_q1;
    end
  end

  a_strobes_apart: assert property (@(posedge clk) disable iff (rst) !(o_tx_stb && o_rx_stb));

endmodule

/* src/sd_cmd_engine.sv */
// SD CMD line engine
// Sends the 48-bit command frame on tx strobes, then optionally waits for
// and receives a 48-bit short response on rx strobes and checks it
module sd_cmd_engine (
  input  logic      clk,
  input  logic      rst,
  input  logic      i_tx_stb,
  input  logic      i_rx_stb,
  input  logic      i_cmd_in,
  output logic      o_cmd_out,
  output logic      o_cmd_oe,
  sd_cmd_if.engine  cmd
);
  import sd_host_pkg::*;

  typedef enum logic [2:0] {IDLE, SEND, WAIT_RESP, RECV, FINISH} state_t;

  state_t                       state;
  logic [5:0]                   bit_cnt;     // Frame position, 48 marks the release strobe
  logic [$clog2(NCR_MAX+1)-1:0] wait_cnt;
  logic                         timed_out;
  logic [CMD_HDR_LEN-1:0]       tx_sr;       // Start, transmission, index, argument
  logic [CMD_FRAME_LEN-1:0]     rx_sr;
  logic [5:0]                   sent_index;
  logic                         resp_exp_q;
  logic [6:0]                   tx_crc;
  logic [6:0]                   rx_crc;
  logic [5:0]                   crc_pos;
  logic                         start_ok;
  logic                         tx_hdr;
  logic                         rx_take;
  logic                         resp_seen;

  // ******************************
  // Transmit side
  // ******************************
  assign start_ok = cmd.start && (state == IDLE || state == FINISH);
  assign tx_hdr   = (state == SEND) && i_tx_stb && (bit_cnt < 6'(CMD_HDR_LEN));
  assign o_cmd_oe = (state == SEND) && (bit_cnt < 6'(CMD_FRAME_LEN));

  always_comb begin
    crc_pos = 6'(CMD_FRAME_LEN - 2) - bit_cnt;  // CRC bit 6 goes out at position 40
    if (bit_cnt < 6'(CMD_HDR_LEN)) begin
      o_cmd_out = tx_sr[CMD_HDR_LEN-1];
    end else if (bit_cnt < 6'(CMD_FRAME_LEN - 1)) begin
      o_cmd_out = tx_crc[crc_pos[2:0]];
    end else begin
      o_cmd_out = 1'b1;                         // End bit, also the idle level
    end
  end

  sd_crc7 tx_crc_inst (
    .clk     (clk),
    .rst     (rst),
    .i_clear (start_ok),
    .i_en    (tx_hdr),
    .i_bit   (tx_sr[CMD_HDR_LEN-1]),
    .o_crc   (tx_crc)
  );

  // ******************************
  // Receive side
  // ******************************
  // The zero start bit is the first bit taken in
  assign rx_take = i_rx_stb && ((state == WAIT_RESP && !i_cmd_in) || state == RECV);

  sd_crc7 rx_crc_inst (
    .clk     (clk),
    .rst     (rst),
    .i_clear (start_ok),
    .i_en    (rx_take && (state == WAIT_RESP || bit_cnt < 6'(CMD_HDR_LEN))),
    .i_bit   (i_cmd_in),
    .o_crc   (rx_crc)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      bit_cnt   <= '0;
      wait_cnt  <= '0;
      timed_out <= 1'b0;
    end else begin
      case (state)
        IDLE, FINISH: begin
          if (start_ok) begin
            state     <= SEND;
            bit_cnt   <= '0;
            timed_out <= 1'b0;
          end else begin
            state <= IDLE;                      // FINISH lasts one cycle
          end
        end
        SEND: if (i_tx_stb) begin
          if (bit_cnt == 6'(CMD_FRAME_LEN)) begin   // Strobe after the end bit releases the line
            state    <= resp_exp_q ? WAIT_RESP : FINISH;
            wait_cnt <= '0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        WAIT_RESP: if (i_rx_stb) begin
          if (!i_cmd_in) begin
            state   <= RECV;
            bit_cnt <= 6'd1;
          end else if (wait_cnt == NCR_MAX - 1) begin
            state     <= FINISH;
            timed_out <= 1'b1;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        RECV: if (i_rx_stb) begin
          if (bit_cnt == 6'(CMD_FRAME_LEN - 1)) state <= FINISH;  // End bit sampled
          bit_cnt <= bit_cnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Frame payload
  always_ff @(posedge clk) begin
    if (start_ok) begin
      tx_sr      <= {2'b01, cmd.index, cmd.arg};
      sent_index <= cmd.index;
      resp_exp_q <= cmd.resp_exp;
    end else if (tx_hdr) begin
      tx_sr <= {tx_sr[CMD_HDR_LEN-2:0], 1'b0};
    end
    if (rx_take) rx_sr <= {rx_sr[CMD_FRAME_LEN-2:0], i_cmd_in};
  end

  // ******************************
  // Result
  // ******************************
  assign resp_seen       = resp_exp_q && !timed_out;
  assign cmd.busy        = (state == SEND) || (state == WAIT_RESP) || (state == RECV);
  assign cmd.done        = (state == FINISH);
  assign cmd.resp_status = rx_sr[39:8];
  assign cmd.timeout     = timed_out;
  assign cmd.crc_err     = resp_seen && ((rx_sr[7:1] != rx_crc) || !rx_sr[0]);
  assign cmd.index_err   = resp_seen && (rx_sr[45:40] != sent_index);

  a_released_on_resp: assert property (@(posedge clk) disable iff (rst)
    (state == WAIT_RESP || state == RECV) |-> !o_cmd_oe);
  a_start_when_idle: assert property (@(posedge clk) disable iff (rst) cmd.start |-> !cmd.busy);

endmodule

/* src/sd_host_regs.sv */
// SD host register block
// AXI4-Lite slave with the CMD, ARG, STATUS, RESP and CLKDIV registers;
// a CMD write issues a command and done latches its result
module sd_host_regs (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [sd_host_pkg::AXI_ADDR_W-1:0] i_awaddr,
  input  logic                               i_awvalid,
  output logic                               o_awready,
  input  logic [sd_host_pkg::AXI_DATA_W-1:0] i_wdata,
  input  logic [3:0]                         i_wstrb,
  input  logic                               i_wvalid,
  output logic                               o_wready,
  output logic [1:0]                         o_bresp,
  output logic                               o_bvalid,
  input  logic                               i_bready,
  input  logic [sd_host_pkg::AXI_ADDR_W-1:0] i_araddr,
  input  logic                               i_arvalid,
  output logic                               o_arready,
  output logic [sd_host_pkg::AXI_DATA_W-1:0] o_rdata,
  output logic [1:0]                         o_rresp,
  output logic                               o_rvalid,
  input  logic                               i_rready,
  output logic [sd_host_pkg::CLKDIV_W-1:0]   o_clk_div,
  sd_cmd_if.requester                        cmd
);
  import sd_host_pkg::*;

  logic                  wr_hs;
  logic                  rd_hs;
  logic                  wr_hit;
  logic                  rd_hit;
  logic [AXI_DATA_W-1:0] rd_word;
  logic [5:0]            cmd_index;
  logic                  cmd_resp_exp;
  logic [31:0]           arg_reg;
  logic [31:0]           resp_reg;
  logic                  start_q;
  logic                  st_done;
  logic                  st_crc_err;
  logic                  st_timeout;
  logic                  st_index_err;

  assign wr_hs  = o_awready && i_awvalid && i_wvalid;   // Address and data taken together
  assign rd_hs  = o_arready && i_arvalid;
  assign wr_hit = (i_awaddr == REG_CMD) || (i_awaddr == REG_ARG) || (i_awaddr == REG_STATUS) ||
                  (i_awaddr == REG_RESP) || (i_awaddr == REG_CLKDIV);

  assign cmd.start    = start_q;
  assign cmd.index    = cmd_index;
  assign cmd.arg      = arg_reg;
  assign cmd.resp_exp = cmd_resp_exp;

  // ******************************
  // Write channel and control state
  // ******************************
  always_ff @(posedge clk) begin
    if (rst) begin
      o_awready    <= 1'b0;
      o_wready     <= 1'b0;
      o_bvalid     <= 1'b0;
      o_bresp      <= RESP_OKAY;
      o_clk_div    <= CLKDIV_RESET;
      cmd_index    <= '0;
      cmd_resp_exp <= 1'b0;
      start_q      <= 1'b0;
      st_done      <= 1'b0;
      st_crc_err   <= 1'b0;
      st_timeout   <= 1'b0;
      st_index_err <= 1'b0;
    end else begin
      start_q   <= 1'b0;
      o_awready <= i_awvalid && i_wvalid && !o_awready && !o_bvalid;  // No new write while B pends
      o_wready  <= i_awvalid && i_wvalid && !o_awready && !o_bvalid;
      if (o_bvalid && i_bready) o_bvalid <= 1'b0;
      if (cmd.done) begin                        // Result latch, a new command below wins
        st_done      <= 1'b1;
        st_crc_err   <= cmd.crc_err;
        st_timeout   <= cmd.timeout;
        st_index_err <= cmd.index_err;
      end
      if (wr_hs) begin
        o_bvalid <= 1'b1;
        o_bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        if (i_awaddr == REG_CMD && !cmd.busy) begin   // Ignored while busy, still OKAY
          cmd_index    <= i_wdata[CMD_INDEX_LSB +: 6];
          cmd_resp_exp <= i_wdata[CMD_RESP_BIT];
          start_q      <= 1'b1;
          st_done      <= 1'b0;
          st_crc_err   <= 1'b0;
          st_timeout   <= 1'b0;
          st_index_err <= 1'b0;
        end
        if (i_awaddr == REG_CLKDIV && i_wstrb[0]) o_clk_div <= i_wdata[CLKDIV_W-1:0];
      end
    end
  end

  // Argument with byte strobes, and the response status from the card
  always_ff @(posedge clk) begin
    if (wr_hs && i_awaddr == REG_ARG) begin
      for (int b = 0; b < 4; b++) begin
        if (i_wstrb[b]) arg_reg[8*b +: 8] <= i_wdata[8*b +: 8];
      end
    end
    if (cmd.done) resp_reg <= cmd.resp_status;
  end

  // ******************************
  // Read channel
  // ******************************
  always_comb begin
    rd_word = '0;
    rd_hit  = 1'b1;
    case (i_araddr)
      REG_CMD: begin
        rd_word[CMD_INDEX_LSB +: 6] = cmd_index;
        rd_word[CMD_RESP_BIT]       = cmd_resp_exp;
      end
      REG_ARG: rd_word = arg_reg;
      REG_STATUS: begin
        rd_word[ST_BUSY]      = cmd.busy;       // Live from the engine
        rd_word[ST_DONE]      = st_done;
        rd_word[ST_CRC_ERR]   = st_crc_err;
        rd_word[ST_TIMEOUT]   = st_timeout;
        rd_word[ST_INDEX_ERR] = st_index_err;
      end
      REG_RESP:   rd_word = resp_reg;
      REG_CLKDIV: rd_word[CLKDIV_W-1:0] = o_clk_div;
      default:    rd_hit = 1'b0;                // Unmapped reads return zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
      o_rresp   <= RESP_OKAY;
    end else begin
      o_arready <= i_arvalid && !o_arready && !o_rvalid;
      if (o_rvalid && i_rready) o_rvalid <= 1'b0;
      if (rd_hs) begin
        o_rvalid <= 1'b1;
        o_rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) o_rdata <= rd_word;
  end

  a_bvalid_held: assert property (@(posedge clk) disable iff (rst)
    o_bvalid && !i_bready |=> o_bvalid);

endmodule

/* src/sd_host_top.sv */
// SD host controller top level
// AXI4-Lite register block, CMD engine and platform layer with plain ports;
// the CMD line leaves as separate out, enable and in signals
module sd_host_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [sd_host_pkg::AXI_ADDR_W-1:0] i_awaddr,
  input  logic                               i_awvalid,
  output logic                               o_awready,
  input  logic [sd_host_pkg::AXI_DATA_W-1:0] i_wdata,
  input  logic [3:0]                         i_wstrb,
  input  logic                               i_wvalid,
  output logic                               o_wready,
  output logic [1:0]                         o_bresp,
  output logic                               o_bvalid,
  input  logic                               i_bready,
  input  logic [sd_host_pkg::AXI_ADDR_W-1:0] i_araddr,
  input  logic                               i_arvalid,
  output logic                               o_arready,
  output logic [sd_host_pkg::AXI_DATA_W-1:0] o_rdata,
  output logic [1:0]                         o_rresp,
  output logic                               o_rvalid,
  input  logic                               i_rready,
  output logic                               o_sd_clk,
  output logic                               o_sd_cmd,
  output logic                               o_sd_cmd_oe,
  input  logic                               i_sd_cmd
);

  logic [sd_host_pkg::CLKDIV_W-1:0] clk_div;
  logic tx_stb;
  logic rx_stb;
  logic cmd_out;
  logic cmd_oe;
  logic cmd_in;

  sd_cmd_if cmd_if ();

  sd_host_regs regs_inst (
    .clk, .rst,
    .i_awaddr, .i_awvalid, .o_awready, .i_wdata, .i_wstrb, .i_wvalid, .o_wready,
    .o_bresp, .o_bvalid, .i_bready,
    .i_araddr, .i_arvalid, .o_arready, .o_rdata, .o_rresp, .o_rvalid, .i_rready,
    .o_clk_div (clk_div),
    .cmd       (cmd_if.requester)
  );

  sd_cmd_engine engine_inst (
    .clk, .rst,
    .i_tx_stb  (tx_stb),
    .i_rx_stb  (rx_stb),
    .i_cmd_in  (cmd_in),
    .o_cmd_out (cmd_out),
    .o_cmd_oe  (cmd_oe),
    .cmd       (cmd_if.engine)
  );

  sd_host_platform platform_inst (
    .clk, .rst,
    .i_clk_div    (clk_div),
    .i_cmd_out    (cmd_out),
    .i_cmd_oe     (cmd_oe),
    .i_cmd_pin    (i_sd_cmd),
    .o_sd_clk     (o_sd_clk),
    .o_tx_stb     (tx_stb),
    .o_rx_stb     (rx_stb),
    .o_cmd_pin    (o_sd_cmd),
    .o_cmd_pin_oe (o_sd_cmd_oe),
    .o_cmd_in     (cmd_in)
  );

endmodule

/* verification/sd_card_model.sv */
// Behavioral SD card on the CMD line
// Captures 48-bit command frames on rising sd_clk edges and, when asked,
// answers with a short response after falling edges, corrupted as the mode says
module sd_card_model (
  input  logic        i_sd_clk,
  input  logic        i_cmd,        // Resolved CMD line
  input  logic        i_respond,    // The current command expects an answer
  input  logic [1:0]  i_mode,       // 0 answer, 1 silent, 2 bad CRC, 3 wrong index
  input  logic [31:0] i_status,     // Card status sent back in the response
  output logic        o_cmd,
  output logic        o_cmd_oe,
  output logic [47:0] o_frame,      // Last captured command frame
  output int          o_count       // Commands captured so far
);

  // CRC7 with x^7 + x^3 + 1, first bit of the frame first
  function automatic logic [6:0] crc7(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      fb  = bits[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  initial begin
    logic [47:0] cap;
    logic [39:0] hdr;
    logic [47:0] resp;
    o_cmd       = 1'b1;
    o_cmd_oe    = 1'b0;
    o_frame     = '0;
    o_count     = 0;
    forever begin
      @(posedge i_sd_clk);
      if (i_cmd == 1'b0) begin             // Start bit of a host command
        cap     = '0;
        for (int i = 46; i >= 0; i--) begin
          @(posedge i_sd_clk);
          cap[i] = i_cmd;
        end
        o_frame     = cap;
        o_count++;
        if (i_respond && i_mode != 2'd1) begin
          hdr = {2'b00, (i_mode == 2'd3) ? ~cap[45:40] : cap[45:40], i_status};
          resp = {hdr, crc7(hdr) ^ ((i_mode == 2'd2) ? 7'h01 : 7'h00), 1'b1};
          repeat (2) @(negedge i_sd_clk);  // Host has released the line by now
          for (int i = 47; i >= 0; i--) begin
            #1;
            o_cmd_oe = 1'b1;
            o_cmd    = resp[i];
            @(negedge i_sd_clk);
          end
          #1;
          o_cmd_oe = 1'b0;
          o_cmd    = 1'b1;
        end
      end
    end
  end

endmodule

/* verification/tb_sd_host.sv */
// SD host controller testbench
// Runs the command tests from the test data file against the DUT and a
// behavioral card, then a busy rewrite test and a register bus test
module tb_sd_host;
  import sd_host_pkg::*;

  localparam int    CLK_PERIOD  = 10;
  localparam int    RST_CYCLES  = 3;
  // Sum of the test lengths, the longest a silent card at divisor 4 near 1,150 cycles, doubled
  localparam int    CYCLE_LIMIT = 20000;
  localparam string DATA_FILE   = "verification/sd_host_testdata.txt";

  logic clk;
  logic rst;
  logic [AXI_ADDR_W-1:0] awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [3:0]  wstrb;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [1:0]  bresp, rresp;
  logic        sd_clk, sd_cmd_host, sd_cmd_oe, sd_cmd_line;
  logic        card_cmd, card_oe, card_respond;
  logic [1:0]  card_mode;
  logic [31:0] card_status;
  logic [47:0] card_frame;
  int          card_count;
  int          seed = 32'h67a7_b11e;
  int          cycle_cnt = 0;
  int          test_errs = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  time         last_rise = 0;
  time         sd_period = 0;

  always #(CLK_PERIOD/2) clk = ~clk;

  // Host drive wins, then the card, else the pull-up
  assign sd_cmd_line = sd_cmd_oe ? sd_cmd_host : (card_oe ? card_cmd : 1'b1);

  sd_host_top sd_host_top_inst (
    .clk, .rst,
    .i_awaddr (awaddr), .i_awvalid (awvalid), .o_awready (awready),
    .i_wdata (wdata), .i_wstrb (wstrb), .i_wvalid (wvalid), .o_wready (wready),
    .o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready),
    .i_araddr (araddr), .i_arvalid (arvalid), .o_arready (arready),
    .o_rdata (rdata), .o_rresp (rresp), .o_rvalid (rvalid), .i_rready (rready),
    .o_sd_clk (sd_clk), .o_sd_cmd (sd_cmd_host), .o_sd_cmd_oe (sd_cmd_oe),
    .i_sd_cmd (sd_cmd_line)
  );

  sd_card_model card_inst (
    .i_sd_clk (sd_clk), .i_cmd (sd_cmd_line), .i_respond (card_respond),
    .i_mode (card_mode), .i_status (card_status), .o_cmd (card_cmd),
    .o_cmd_oe (card_oe), .o_frame (card_frame),
    .o_count (card_count)
  );

  always @(posedge sd_clk) begin
    sd_period = $time - last_rise;        // Last full sd_clk period
    last_rise = $time;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a test never finished", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // ******************************
  // Reporting
  // ******************************
  task automatic log_mismatch(input string test, input string what,
                              input logic [63:0] exp, input logic [63:0] act);
    $display("ERROR %s: %s expected %h actual %h", test, what, exp, act);
    test_errs++;
  endtask

  task automatic close_test(input string test);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("PASS %s", test);
    end else begin
      fail_cnt++;
      $display("FAIL %s with %0d errors", test, test_errs);
    end
    test_errs = 0;
  endtask

  // ******************************
  // AXI4-Lite master
  // ******************************
  // Both tasks start and end 1 unit after a rising edge
  task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int delay;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!awready);
    if (wready !== 1'b1) log_mismatch("axi_write", "WREADY with AWREADY", 1, wready);
    @(posedge clk);                       // Address and data taken on this edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    delay   = $unsigned($random(seed)) % 4;
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
    bready = 1'b1;
    while (!bvalid) begin
      @(posedge clk);
      #1;
    end
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int delay;
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!arready);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    delay   = $unsigned($random(seed)) % 4;
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
    rready = 1'b1;
    while (!rvalid) begin
      @(posedge clk);
      #1;
    end
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  function automatic logic [31:0] cmd_word(input logic [5:0] index, input logic resp_exp);
    logic [31:0] w;
    w = '0;
    w[CMD_INDEX_LSB +: 6] = index;
    w[CMD_RESP_BIT]       = resp_exp;
    return w;
  endfunction

  // CRC7 of a command header with x^7 + x^3 + 1, first bit first
  function automatic logic [6:0] header_crc7(input logic [39:0] hdr);
    logic [6:0] crc;
    logic       fb;
    crc = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      fb  = hdr[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  // Poll STATUS until DONE is set
  task automatic wait_done(output logic [31:0] status);
    logic [1:0] rr;
    status = '0;
    while (!status[ST_DONE]) axi_read(REG_STATUS, status, rr);
  endtask

  // ******************************
  // Tests
  // ******************************
  task automatic check_reset_state();
    logic [31:0] rd;
    logic [1:0]  rr;
    if (sd_cmd_oe !== 1'b0) log_mismatch("reset_state", "CMD enable", 0, sd_cmd_oe);
    axi_read(REG_STATUS, rd, rr);
    if (rd !== 32'd0) log_mismatch("reset_state", "STATUS", 0, rd);
    axi_read(REG_CLKDIV, rd, rr);
    if (rd !== 32'd4) log_mismatch("reset_state", "CLKDIV", 4, rd);
    close_test("reset_state");
  endtask

  task automatic run_command(input string name, input logic [31:0] div, input logic [31:0] idx,
                             input logic [31:0] arg, input logic [31:0] resp,
                             input logic [31:0] mode, input logic [31:0] rsp_status,
                             input logic [31:0] exp_st);
    logic [31:0] rd;
    logic [1:0]  rr;
    logic [39:0] exp_hdr;
    logic [47:0] exp_frame;
    int          count_before;
    card_respond = resp[0];
    card_mode    = mode[1:0];
    card_status  = rsp_status;
    axi_write(REG_CLKDIV, div, 4'hF, rr);
    axi_write(REG_ARG, arg, 4'hF, rr);
    count_before = card_count;
    axi_write(REG_CMD, cmd_word(idx[5:0], resp[0]), 4'hF, rr);
    wait_done(rd);
    if (rd != exp_st) log_mismatch(name, "STATUS", exp_st, rd);
    if (resp[0] && mode != 1) begin      // A silent card leaves RESP undefined
      axi_read(REG_RESP, rd, rr);
      if (rd != rsp_status) log_mismatch(name, "RESP", rsp_status, rd);
    end
    if (card_count != count_before + 1) begin
      log_mismatch(name, "commands at card", count_before + 1, card_count);
    end
    exp_hdr   = {2'b01, idx[5:0], arg};
    exp_frame = {exp_hdr, header_crc7(exp_hdr), 1'b1};
    if (card_frame != exp_frame) log_mismatch(name, "command frame", exp_frame, card_frame);
    if (sd_period != 2 * (div + 1) * CLK_PERIOD) begin
      log_mismatch(name, "sd_clk period", 2 * (div + 1) * CLK_PERIOD, sd_period);
    end
    close_test(name);
  endtask

  // A second CMD write while busy must not reach the card
  task automatic check_busy_rewrite();
    logic [31:0] rd;
    logic [1:0]  rr;
    int          count_before;
    card_respond = 1'b0;
    axi_write(REG_CLKDIV, 32'd1, 4'hF, rr);
    axi_write(REG_ARG, 32'h0000_00a5, 4'hF, rr);
    count_before = card_count;
    axi_write(REG_CMD, cmd_word(6'h05, 1'b0), 4'hF, rr);
    axi_read(REG_STATUS, rd, rr);
    if (!rd[ST_BUSY]) log_mismatch("busy_rewrite", "STATUS busy", 1, rd[ST_BUSY]);
    axi_write(REG_CMD, cmd_word(6'h06, 1'b0), 4'hF, rr);
    if (rr != RESP_OKAY) log_mismatch("busy_rewrite", "BRESP", RESP_OKAY, rr);
    wait_done(rd);
    if (rd != 32'h2) log_mismatch("busy_rewrite", "STATUS", 32'h2, rd);
    if (card_count != count_before + 1) begin
      log_mismatch("busy_rewrite", "commands at card", count_before + 1, card_count);
    end
    if (card_frame[45:40] != 6'h05) log_mismatch("busy_rewrite", "index", 5, card_frame[45:40]);
    close_test("busy_rewrite");
  endtask

  task automatic check_register_bus();
    logic [31:0] rd;
    logic [1:0]  rr;
    axi_write(REG_ARG, 32'hffff_ffff, 4'hF, rr);
    axi_write(REG_ARG, 32'h1234_5678, 4'b0101, rr);   // Bytes 0 and 2 only
    axi_read(REG_ARG, rd, rr);
    if (rd != 32'hff34_ff78) log_mismatch("register_bus", "ARG", 32'hff34_ff78, rd);
    axi_write(5'h14, 32'hdead_beef, 4'hF, rr);
    if (rr != RESP_SLVERR) log_mismatch("register_bus", "unmapped BRESP", RESP_SLVERR, rr);
    axi_read(5'h14, rd, rr);
    if (rr != RESP_SLVERR) log_mismatch("register_bus", "unmapped RRESP", RESP_SLVERR, rr);
    if (rd != 32'd0) log_mismatch("register_bus", "unmapped RDATA", 0, rd);
    axi_read(REG_ARG, rd, rr);
    if (rd != 32'hff34_ff78) log_mismatch("register_bus", "ARG kept", 32'hff34_ff78, rd);
    if (rr != RESP_OKAY) log_mismatch("register_bus", "ARG RRESP", RESP_OKAY, rr);
    close_test("register_bus");
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] f_div, f_idx, f_arg, f_resp, f_mode, f_status, f_exp;
    clk          = 1'b0;
    rst          = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    card_respond = 1'b0;
    card_mode    = '0;
    card_status  = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    check_reset_state();
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Could not open %s, no command tests were run", DATA_FILE);
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h", name, f_div, f_idx, f_arg,
                    f_resp, f_mode, f_status, f_exp);
        if (n != 8) continue;
        run_command(name, f_div, f_idx, f_arg, f_resp, f_mode, f_status, f_exp);
      end
      $fclose(fd);
    end
    check_busy_rewrite();
    check_register_bus();
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* all.f */
src/sd_host_pkg.sv
src/sd_cmd_if.sv
src/sd_crc7.sv
src/sd_host_platform.sv
src/sd_cmd_engine.sv
src/sd_host_regs.sv
src/sd_host_top.sv
verification/sd_card_model.sv
verification/tb_sd_host.sv

/* Makefile */
# Verilator build and run for the SD host controller
VERILATOR  ?= verilator
TOP        ?= tb_sd_host
RTL_TOP    ?= sd_host_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(shell grep '^src/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/sd_host_testdata.txt */
# Columns: name divisor index arg resp_expected card_mode resp_status expected_status, in hex
# Card mode 0 answers, 1 stays silent, 2 sends a bad CRC, 3 echoes a wrong index
go_idle_cmd0        2 00 00000000 0 0 00000000 02
send_if_cond_cmd8   2 08 000001aa 1 0 000001aa 02
app_cmd_cmd55       1 37 00000000 1 0 00000120 02
send_status_cmd13   3 0d 12340000 1 0 00000900 02
select_card_cmd7    4 07 abcd0000 1 0 00000700 02
set_blocklen_cmd16  1 10 00000200 1 0 00000900 02
read_block_silent   4 11 00000000 1 1 00000000 0a
bad_crc_cmd13       2 0d 12340000 1 2 00000900 06
wrong_index_cmd16   3 10 00000200 1 3 00000900 12
inactive_cmd15      4 0f 56780000 0 0 00000000 02
